//--- midi_defs.svh
`ifndef MIDI_DEFS_SVH
`define MIDI_DEFS_SVH

// number of synthesizer voices
`define NUM_VOICES 32

// width of a voice index
`define VOICE_BITS 5

// one tracker entry per MIDI note number
`define NOTE_DEPTH 128

// width of a raw MIDI byte, data bytes use the lower seven bits
`define MIDI_BYTE 8

`endif

//--- midi_pkg.sv
`default_nettype none

`include "midi_defs.svh"

package midi_pkg;

    // high nibble of a channel status byte
    typedef enum logic [3:0] {
        NOTE_OFF_OP = 4'h8,
        NOTE_ON_OP  = 4'h9,
        CONTROL_OP  = 4'hB,
        OTHER_OP    = 4'h0
    } midi_opcode_t;

    // message handler FSM
    typedef enum logic [2:0] {
        IDLE,
        HANDLE,
        NOTE_OFF,
        NOTE_ON,
        CONTROLLER,
        WAIT,
        DONE
    } handler_state_t;

    // byte parser FSM
    typedef enum logic [1:0] {
        WAIT_STATUS,
        WAIT_DATA1,
        WAIT_DATA2
    } parser_state_t;

    typedef logic [`VOICE_BITS-1:0] voice_idx_t;

endpackage

`default_nettype wire

//--- midi_msg_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "midi_defs.svh"

// one complete channel message, valid for a single cycle
interface midi_msg_if;

    logic                  valid;
    logic [`MIDI_BYTE-1:0] status;
    logic [`MIDI_BYTE-2:0] data1;
    logic [`MIDI_BYTE-2:0] data2;

    modport source (
        output valid, status, data1, data2
    );

    modport sink (
        input valid, status, data1, data2
    );

endinterface

`default_nettype wire

//--- midi_byte_parser.sv
`timescale 1ns/10ps
`default_nettype none

`include "midi_defs.svh"

module midi_byte_parser (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  byte_valid,
    input  wire logic [`MIDI_BYTE-1:0] byte_data,
    midi_msg_if.source                 msg
);

    import midi_pkg::*;

    parser_state_t         state;
    logic [`MIDI_BYTE-1:0] running_status;
    logic [`MIDI_BYTE-2:0] data1_q;
    logic                  is_status;
    logic                  is_system;
    logic                  tracked_op;

    assign is_status = byte_data[`MIDI_BYTE-1];
    // system common and real-time bytes, ignored
    assign is_system = (byte_data[7:4] == 4'hF);
    // only the two-data-byte opcodes the handler acts on are followed
    assign tracked_op = byte_data[7:4] inside {NOTE_OFF_OP, NOTE_ON_OP, CONTROL_OP};

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= WAIT_STATUS;
            msg.valid <= 1'b0;
        end else begin
            msg.valid <= 1'b0;
            if (byte_valid) begin
                if (is_status) begin
                    // a new channel status restarts the data count
                    if (!is_system) begin
                        state <= tracked_op ? WAIT_DATA1 : WAIT_STATUS;
                    end
                end else begin
                    case (state)
                        WAIT_DATA1: state <= WAIT_DATA2;
                        WAIT_DATA2: begin
                            msg.valid <= 1'b1;
                            // running status, next pair reuses the same status
                            state <= WAIT_DATA1;
                        end
                        // data without a status byte is dropped
                        default: state <= WAIT_STATUS;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid && is_status && !is_system) begin
            running_status <= byte_data;
        end
        if (byte_valid && !is_status && state == WAIT_DATA1) begin
            data1_q <= byte_data[`MIDI_BYTE-2:0];
        end
        if (byte_valid && !is_status && state == WAIT_DATA2) begin
            msg.status <= running_status;
            msg.data1  <= data1_q;
            msg.data2  <= byte_data[`MIDI_BYTE-2:0];
        end
    end

    // two data bytes separate any two messages
    a_valid_single: assert property (@(posedge clk) disable iff (reset)
        msg.valid |=> !msg.valid);

endmodule

`default_nettype wire

//--- voice_allocator.sv
`timescale 1ns/10ps
`default_nettype none

`include "midi_defs.svh"

module voice_allocator (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [`NUM_VOICES-1:0] playing,
    input  wire logic                   update_mixer,
    output midi_pkg::voice_idx_t        free_voice,
    output logic                        all_busy,
    output logic [`VOICE_BITS:0]        active_count,
    output logic [7:0]                  gain
);

    import midi_pkg::*;

    typedef logic [7:0] gain_table_t [0:`NUM_VOICES];

    // mixer gain per active voice count, full scale when silent
    function automatic gain_table_t build_gain_table();
        gain_table_t table_out;
        for (int n = 0; n <= `NUM_VOICES; n++) begin
            if (n == 0) begin
                table_out[n] = 8'd255;
            end else begin
                table_out[n] = 8'(255 / n);
            end
        end
        return table_out;
    endfunction

    localparam gain_table_t GAIN_TABLE = build_gain_table();

    // population count of the playing vector
    always_comb begin
        active_count = '0;
        for (int i = 0; i < `NUM_VOICES; i++) begin
            active_count = active_count + (`VOICE_BITS+1)'(playing[i]);
        end
    end

    // lowest clear bit wins, scanned from the top so it is written last
    always_comb begin
        free_voice = '0;
        for (int i = `NUM_VOICES - 1; i >= 0; i--) begin
            if (!playing[i]) begin
                free_voice = voice_idx_t'(i);
            end
        end
    end

    assign all_busy = &playing;

    // gain only moves on the mixer strobe so the level changes between frames
    always_ff @(posedge clk) begin
        if (reset) begin
            gain <= '0;
        end else if (update_mixer) begin
            gain <= GAIN_TABLE[active_count];
        end
    end

endmodule

`default_nettype wire

//--- voice_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "midi_defs.svh"

module voice_table (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  voice_we,
    input  wire midi_pkg::voice_idx_t  voice_addr,
    input  wire logic [`MIDI_BYTE-2:0] voice_note,
    input  wire logic [`MIDI_BYTE-2:0] voice_velocity,
    input  wire logic                  voice_on,
    output logic [`NUM_VOICES-1:0]     playing
);

    localparam int DATA_W = `MIDI_BYTE - 1;

    // per voice entry, note in the upper half and velocity in the lower half
    logic [2*DATA_W-1:0] voice_regs [0:`NUM_VOICES-1];
    logic [DATA_W-1:0]   stored_note;

    assign stored_note = voice_regs[voice_addr][2*DATA_W-1:DATA_W];

    always_ff @(posedge clk) begin
        if (voice_we) begin
            voice_regs[voice_addr] <= {voice_note, voice_velocity};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            playing <= '0;
        end else if (voice_we) begin
            playing[voice_addr] <= voice_on;
        end
    end

    // allocator and handler must only start voices that are silent
    a_on_to_free: assert property (@(posedge clk) disable iff (reset)
        voice_we && voice_on |-> !playing[voice_addr]);

    // tracker lookup in the handler must point at the voice holding that note
    a_off_matches_note: assert property (@(posedge clk) disable iff (reset)
        voice_we && !voice_on && playing[voice_addr] |-> stored_note == voice_note);

endmodule

`default_nettype wire

//--- midi_msg_handler.sv
`timescale 1ns/10ps
`default_nettype none

`include "midi_defs.svh"

module midi_msg_handler (
    input  wire logic                  clk,
    input  wire logic                  reset,
    midi_msg_if.sink                   msg,
    input  wire midi_pkg::voice_idx_t  free_voice,
    input  wire logic                  all_busy,
    input  wire logic                  ready_to_update,
    output logic                       voice_we,
    output midi_pkg::voice_idx_t       voice_addr,
    output logic [`MIDI_BYTE-2:0]      voice_note,
    output logic [`MIDI_BYTE-2:0]      voice_velocity,
    output logic                       voice_on,
    output logic [15:0]                controller_values,
    output logic                       update_all,
    output logic [`NUM_VOICES-1:0]     update_note
);

    import midi_pkg::*;

    handler_state_t         state;
    handler_state_t         next_state;
    midi_opcode_t           opcode_q;
    logic [`MIDI_BYTE-2:0]  data1_q;
    logic [`MIDI_BYTE-2:0]  data2_q;
    voice_idx_t             note_tracker [0:`NOTE_DEPTH-1];
    voice_idx_t             tracked_voice;
    logic [`NUM_VOICES-1:0] pending_mask;
    logic                   pending_all;

    function automatic midi_opcode_t decode_opcode(input logic [3:0] nibble);
        case (nibble)
            4'h8:    return NOTE_OFF_OP;
            4'h9:    return NOTE_ON_OP;
            4'hB:    return CONTROL_OP;
            default: return OTHER_OP;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (msg.valid) next_state = HANDLE;
            end
            HANDLE: begin
                case (opcode_q)
                    NOTE_OFF_OP: next_state = NOTE_OFF;
                    NOTE_ON_OP: begin
                        // velocity zero is a note-off in disguise
                        if (data2_q == '0) begin
                            next_state = NOTE_OFF;
                        end else if (all_busy) begin
                            next_state = IDLE;
                        end else begin
                            next_state = NOTE_ON;
                        end
                    end
                    CONTROL_OP: next_state = CONTROLLER;
                    default:    next_state = IDLE;
                endcase
            end
            NOTE_OFF, NOTE_ON, CONTROLLER: next_state = WAIT;
            WAIT: begin
                if (ready_to_update) next_state = DONE;
            end
            default: next_state = IDLE;
        endcase
    end

    // messages arriving while busy are lost
    always_ff @(posedge clk) begin
        if (state == IDLE && msg.valid) begin
            opcode_q <= decode_opcode(msg.status[7:4]);
            data1_q  <= msg.data1;
            data2_q  <= msg.data2;
        end
    end

    // note number to voice map, read registered so HANDLE sets up NOTE_OFF
    always_ff @(posedge clk) begin
        if (state == NOTE_ON) begin
            note_tracker[data1_q] <= free_voice;
        end
        tracked_voice <= note_tracker[data1_q];
    end

    assign voice_we       = (state == NOTE_ON) || (state == NOTE_OFF);
    assign voice_on       = (state == NOTE_ON);
    assign voice_addr     = voice_on ? free_voice : tracked_voice;
    assign voice_note     = data1_q;
    assign voice_velocity = data2_q;

    // changes collect here until the frame tick lets them out
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_mask      <= '0;
            pending_all       <= 1'b0;
            controller_values <= '0;
        end else begin
            if (voice_we) begin
                pending_mask[voice_addr] <= 1'b1;
            end
            if (state == CONTROLLER) begin
                controller_values <= {1'b0, data2_q, 1'b0, data1_q};
                pending_all       <= 1'b1;
            end
            if (state == DONE) begin
                pending_mask <= '0;
                pending_all  <= 1'b0;
            end
        end
    end

    assign update_all  = (state == DONE) && pending_all;
    assign update_note = (state == DONE) ? pending_mask : '0;

    // a note-on write only lands while the allocator still offers a free voice
    a_on_not_busy: assert property (@(posedge clk) disable iff (reset)
        voice_we && voice_on |-> !all_busy);

endmodule

`default_nettype wire

//--- midi_voice_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "midi_defs.svh"

module midi_voice_ctrl_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   byte_valid,
    input  wire logic [`MIDI_BYTE-1:0]  byte_data,
    input  wire logic                   ready_to_update,
    input  wire logic                   update_mixer,
    output wire logic                   voice_we,
    output wire logic [`VOICE_BITS-1:0] voice_addr,
    output wire logic [`MIDI_BYTE-2:0]  voice_note,
    output wire logic [`MIDI_BYTE-2:0]  voice_velocity,
    output wire logic                   voice_on,
    output wire logic [15:0]            controller_values,
    output wire logic                   update_all,
    output wire logic [`NUM_VOICES-1:0] update_note,
    output wire logic [7:0]             gain,
    output wire logic [`NUM_VOICES-1:0] playing
);

    logic [`VOICE_BITS-1:0] free_voice;
    logic                   all_busy;

    midi_msg_if msg_bus ();

    midi_byte_parser i_parser (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .msg        (msg_bus.source)
    );

    midi_msg_handler i_handler (
        .clk               (clk),
        .reset             (reset),
        .msg               (msg_bus.sink),
        .free_voice        (free_voice),
        .all_busy          (all_busy),
        .ready_to_update   (ready_to_update),
        .voice_we          (voice_we),
        .voice_addr        (voice_addr),
        .voice_note        (voice_note),
        .voice_velocity    (voice_velocity),
        .voice_on          (voice_on),
        .controller_values (controller_values),
        .update_all        (update_all),
        .update_note       (update_note)
    );

    // active count only feeds the gain lookup inside the allocator
    voice_allocator i_allocator (
        .clk          (clk),
        .reset        (reset),
        .playing      (playing),
        .update_mixer (update_mixer),
        .free_voice   (free_voice),
        .all_busy     (all_busy),
        .active_count (),
        .gain         (gain)
    );

    voice_table i_voice_table (
        .clk            (clk),
        .reset          (reset),
        .voice_we       (voice_we),
        .voice_addr     (voice_addr),
        .voice_note     (voice_note),
        .voice_velocity (voice_velocity),
        .voice_on       (voice_on),
        .playing        (playing)
    );

endmodule

`default_nettype wire

//--- tb_midi_voice_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "midi_defs.svh"

module tb_midi_voice_ctrl;

    import midi_pkg::*;

    localparam int TIMEOUT = 200;

    logic                   clk;
    logic                   reset;
    logic                   byte_valid;
    logic [`MIDI_BYTE-1:0]  byte_data;
    logic                   ready_to_update;
    logic                   update_mixer;
    logic                   voice_we;
    voice_idx_t             voice_addr;
    logic [`MIDI_BYTE-2:0]  voice_note;
    logic [`MIDI_BYTE-2:0]  voice_velocity;
    logic                   voice_on;
    logic [15:0]            controller_values;
    logic                   update_all;
    logic [`NUM_VOICES-1:0] update_note;
    logic [7:0]             gain;
    logic [`NUM_VOICES-1:0] playing;

    // reference view of the sounding voices
    logic [`NUM_VOICES-1:0] ref_playing;
    logic [31:0]            lcg_state;
    int                     mismatch_count;
    int                     fail_count;

    midi_voice_ctrl_top i_dut (
        .clk               (clk),
        .reset             (reset),
        .byte_valid        (byte_valid),
        .byte_data         (byte_data),
        .ready_to_update   (ready_to_update),
        .update_mixer      (update_mixer),
        .voice_we          (voice_we),
        .voice_addr        (voice_addr),
        .voice_note        (voice_note),
        .voice_velocity    (voice_velocity),
        .voice_on          (voice_on),
        .controller_values (controller_values),
        .update_all        (update_all),
        .update_note       (update_note),
        .gain              (gain),
        .playing           (playing)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // idle gap of 0 to 3 cycles before each byte
    function automatic int random_gap();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[17:16]);
    endfunction

    function automatic voice_idx_t lowest_free(input logic [`NUM_VOICES-1:0] vec);
        for (int i = 0; i < `NUM_VOICES; i++) begin
            if (!vec[i]) return voice_idx_t'(i);
        end
        return '0;
    endfunction

    // full scale when silent, otherwise shared between the active voices
    function automatic logic [7:0] expected_gain(input logic [`NUM_VOICES-1:0] vec);
        int count;
        count = $countones(vec);
        return (count == 0) ? 8'd255 : 8'(255 / count);
    endfunction

    task automatic check_voice(input string name, input voice_idx_t expected,
                               input voice_idx_t actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("Mismatch %s: expected voice %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_data(input string name, input logic [`MIDI_BYTE-2:0] expected,
                              input logic [`MIDI_BYTE-2:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_mask(input string name, input logic [`NUM_VOICES-1:0] expected,
                              input logic [`NUM_VOICES-1:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_gain(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("Mismatch %s: expected gain %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic send_message(input int count, input logic [7:0] b0, b1, b2);
        logic [7:0] msg_bytes [3];
        msg_bytes[0] = b0;
        msg_bytes[1] = b1;
        msg_bytes[2] = b2;
        for (int i = 0; i < count; i++) begin
            repeat (random_gap()) @(posedge clk);
            @(posedge clk);
            byte_valid <= 1'b1;
            byte_data  <= msg_bytes[i];
            @(posedge clk);
            byte_valid <= 1'b0;
        end
    endtask

    task automatic wait_for_write(input string name, output logic found);
        found = 1'b0;
        for (int i = 0; i < TIMEOUT && !found; i++) begin
            @(negedge clk);
            found = voice_we;
        end
        if (!found) begin
            fail_count++;
            $display("%s: no voice write within %0d cycles", name, TIMEOUT);
        end
    endtask

    task automatic release_frame(input string name, input logic exp_all,
                                 input logic [`NUM_VOICES-1:0] exp_mask);
        logic found;
        found = 1'b0;
        // handler sits in WAIT, nothing may leave before the tick
        repeat (3) begin
            @(negedge clk);
            if (update_all || update_note != '0) begin
                fail_count++;
                $display("%s: update released before the frame tick", name);
            end
        end
        @(posedge clk);
        ready_to_update <= 1'b1;
        for (int i = 0; i < TIMEOUT && !found; i++) begin
            @(negedge clk);
            found = update_all || update_note != '0;
        end
        if (found) begin
            check_flag({name, "_all"}, exp_all, update_all);
            check_mask({name, "_mask"}, exp_mask, update_note);
        end else begin
            fail_count++;
            $display("%s: no update pulse within %0d cycles of the frame tick", name, TIMEOUT);
        end
        @(posedge clk);
        ready_to_update <= 1'b0;
    endtask

    task automatic expect_no_activity(input string name);
        repeat (8) begin
            @(negedge clk);
            if (voice_we || update_all || update_note != '0) begin
                fail_count++;
                $display("%s: dropped message caused a voice write or update", name);
            end
        end
    endtask

    task automatic run_note(input string name, input int count, input logic [7:0] b0, b1, b2,
                            input int tick, input voice_idx_t exp_voice, input logic exp_on,
                            input logic [`NUM_VOICES-1:0] exp_mask);
        logic                  found;
        logic [`MIDI_BYTE-2:0] exp_note;
        logic [`MIDI_BYTE-2:0] exp_velocity;
        // under running status the data bytes come first
        if (count == 3) begin
            exp_note     = b1[`MIDI_BYTE-2:0];
            exp_velocity = b2[`MIDI_BYTE-2:0];
        end else begin
            exp_note     = b0[`MIDI_BYTE-2:0];
            exp_velocity = b1[`MIDI_BYTE-2:0];
        end
        send_message(count, b0, b1, b2);
        if (tick == 0) begin
            expect_no_activity(name);
        end else begin
            wait_for_write(name, found);
            if (found) begin
                check_voice(name, exp_voice, voice_addr);
                check_flag({name, "_on"}, exp_on, voice_on);
                check_data({name, "_note"}, exp_note, voice_note);
                if (exp_on) begin
                    check_data({name, "_velocity"}, exp_velocity, voice_velocity);
                end
                ref_playing[exp_voice] = exp_on;
                @(negedge clk);
                check_mask({name, "_playing"}, ref_playing, playing);
                release_frame(name, 1'b0, exp_mask);
            end
        end
    endtask

    task automatic strobe_mixer(input string name, input logic [7:0] exp_gain);
        @(posedge clk);
        update_mixer <= 1'b1;
        @(posedge clk);
        update_mixer <= 1'b0;
        @(negedge clk);
        check_gain(name, exp_gain, gain);
        check_gain({name, "_model"}, expected_gain(ref_playing), gain);
    endtask

    initial begin
        string                  line;
        string                  name;
        string                  kind;
        int                     fd;
        int                     fields;
        int                     count;
        int                     tick;
        int                     exp_on;
        logic [7:0]             b0, b1, b2;
        logic [7:0]             exp_voice;
        logic [`NUM_VOICES-1:0] exp_mask;
        logic [15:0]            exp_ctrl;
        logic [7:0]             exp_gain;
        voice_idx_t             fill_voice;
        logic [`NUM_VOICES-1:0] fill_mask;
        reset           = 1'b1;
        byte_valid      = 1'b0;
        byte_data       = '0;
        ready_to_update = 1'b0;
        update_mixer    = 1'b0;
        ref_playing     = '0;
        lcg_state       = 32'd49;
        mismatch_count  = 0;
        fail_count      = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        fd = $fopen("midi_patterns.txt", "r");
        if (fd == 0) begin
            fail_count++;
            $display("could not open the pattern file midi_patterns.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") continue;
                fields = $sscanf(line, "%s %s %d %h %h %h %d %h %d %h %h %h", name, kind,
                                 count, b0, b1, b2, tick, exp_voice, exp_on, exp_mask,
                                 exp_ctrl, exp_gain);
                if (fields != 12) begin
                    fail_count++;
                    $display("malformed pattern line: %s", line);
                end else if (kind == "n") begin
                    run_note(name, count, b0, b1, b2, tick, voice_idx_t'(exp_voice),
                             exp_on != 0, exp_mask);
                end else if (kind == "c") begin
                    send_message(count, b0, b1, b2);
                    release_frame(name, 1'b1, '0);
                    check_word(name, exp_ctrl, controller_values);
                end else if (kind == "r") begin
                    // the model picks each voice, lowest free first
                    for (int i = 0; i < int'(b2); i++) begin
                        fill_voice = lowest_free(ref_playing);
                        fill_mask = '0;
                        fill_mask[fill_voice] = 1'b1;
                        run_note($sformatf("%s_%0d", name, i), 3, b0, b1 + 8'(i), 8'h40,
                                 1, fill_voice, 1'b1, fill_mask);
                    end
                end else begin
                    strobe_mixer(name, exp_gain);
                end
            end
            $fclose(fd);
        end
        $display("checks done: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
midi_pkg.sv
midi_msg_if.sv
midi_byte_parser.sv
voice_allocator.sv
voice_table.sv
midi_msg_handler.sv
midi_voice_ctrl_top.sv
tb_midi_voice_ctrl.sv

//--- midi_patterns.txt
# name kind count b0 b1 b2 tick voice on mask ctrl gain (all hex except count, tick, on)
# kind n note message, c controller, r note-ons from note b1 for b2 voices, m mixer strobe
mix_idle    m 0 00 00 00 0 00 0 00000000 0000 ff
on_c4       n 3 90 3c 40 1 00 1 00000001 0000 00
on_e4       n 3 90 40 50 1 01 1 00000002 0000 00
on_g4       n 3 90 43 60 1 02 1 00000004 0000 00
off_e4      n 3 80 40 00 1 01 0 00000002 0000 00
on_a4       n 3 90 45 30 1 01 1 00000002 0000 00
vel0_c4     n 3 90 3c 00 1 00 0 00000001 0000 00
run_on      n 3 90 48 20 1 00 1 00000001 0000 00
run_off     n 2 48 00 00 1 00 0 00000001 0000 00
ctrl_vol    c 3 b0 07 64 1 00 0 00000000 6407 00
mix_two     m 0 00 00 00 0 00 0 00000000 0000 7f
fill        r 3 90 50 1e 1 00 1 00000000 0000 00
on_full     n 3 90 70 40 0 00 0 00000000 0000 00
mix_full    m 0 00 00 00 0 00 0 00000000 0000 07
